// ==== rtl/rp8_pkg.sv ====
// rp8 shared definitions: widths, i/o map, flag masks and core types
package rp8_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned PAW  = 11; // program address, 2048 words
  localparam int unsigned IW   = 16; // instruction word
  localparam int unsigned NGPR = 32; // general registers

  ////////////////////////////////////////////////////////////
  // i/o map
  ////////////////////////////////////////////////////////////

  localparam logic [5:0] IOA_SREG     = 6'h3f; // status register
  localparam logic [5:0] IOA_SPR_BASE = 6'h38; // 0x38..0x3f stay inside the core

  // flags touched by an instruction class, bit order i t h s v n z c
  localparam logic [7:0] MSK_ARITH = 8'h3f; // h s v n z c
  localparam logic [7:0] MSK_LOGIC = 8'h1e; // s v n z, v comes out as 0

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // register file, addressed by byte or by even/odd pair
  typedef union packed {
    logic [NGPR-1:0][7:0]    idx;  // r31..r0
    logic [NGPR/2-1:0][15:0] pair; // r31:r30..r1:r0
  } gpr_t;

  // status register layout
  typedef struct packed {
    logic i; // global irq enable, kept only as storage here
    logic t; // bit copy storage
    logic h; // half carry
    logic s; // sign, n ^ v
    logic v; // two's complement overflow
    logic n; // negative
    logic z; // zero
    logic c; // carry / borrow
  } sreg_t;

  // alu operation select
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0, // a + b + ci
    ALU_SUB = 3'd1, // a - b - ci
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_EOR = 3'd4,
    ALU_MOV = 3'd5  // pass b through
  } alu_mode_t;

  // fetch sequencing
  typedef enum logic [1:0] {
    FS_RESET = 2'd0, // bus idle
    FS_FIRST = 2'd1, // address 0 goes out, returned word is junk
    FS_RUN   = 2'd2  // one insn per ready cycle
  } fetch_state_t;

endpackage

// ==== rtl/rp8_alu.sv ====
// rp8 byte alu, add/sub with carry, logic ops, pass, and avr status flags
`timescale 1ns/1ns

module rp8_alu (
  input  rp8_pkg::alu_mode_t mode,
  input  logic [7:0]         a,   // destination operand
  input  logic [7:0]         b,   // source operand or immediate
  input  logic               ci,  // carry / borrow in
  output logic [7:0]         res,
  output rp8_pkg::sreg_t     flags
);
  import rp8_pkg::*;

  logic [8:0] sum;    // bit 8 is carry out, or borrow for sub
  logic       is_sub;
  logic       is_log; // and/or/eor

  ////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////

  always_comb begin
    sum    = '0;
    is_sub = 1'b0;
    is_log = 1'b0;
    case (mode)
      ALU_ADD: begin
        sum = {1'b0, a} + {1'b0, b} + {8'h00, ci};
        res = sum[7:0];
      end
      ALU_SUB: begin
        sum    = {1'b0, a} - {1'b0, b} - {8'h00, ci};
        res    = sum[7:0];
        is_sub = 1'b1;
      end
      ALU_AND: begin
        res    = a & b;
        is_log = 1'b1;
      end
      ALU_OR: begin
        res    = a | b;
        is_log = 1'b1;
      end
      ALU_EOR: begin
        res    = a ^ b;
        is_log = 1'b1;
      end
      default: res = b; // mov, ldi, in
    endcase
  end

  ////////////////////////////////////////////////////////////
  // flags
  ////////////////////////////////////////////////////////////

  always_comb begin
    flags.i = 1'b0; // never set from alu
    flags.t = 1'b0;
    if (is_sub) begin
      flags.h = ~a[3] & b[3] | b[3] & res[3] | res[3] & ~a[3]; // borrow from bit 3
      flags.v = a[7] & ~b[7] & ~res[7] | ~a[7] & b[7] & res[7];
    end else begin
      flags.h = a[3] & b[3] | b[3] & ~res[3] | ~res[3] & a[3];
      flags.v = a[7] & b[7] & ~res[7] | ~a[7] & ~b[7] & res[7];
    end
    if (is_log) begin
      flags.v = 1'b0;
    end
    flags.c = sum[8];
    flags.n = res[7];
    flags.z = ~|res;
    flags.s = flags.n ^ flags.v;
  end

endmodule

// ==== rtl/rp8_gpr.sv ====
// rp8 general register file, byte and pair write, two byte reads and one pair read
`timescale 1ns/1ns

module rp8_gpr (
  input  logic        clk,
  input  logic        we, // write enable
  input  logic        ww, // pair write, wa[0] ignored
  input  logic [4:0]  wa, // write address
  input  logic [4:0]  ra, // destination byte read
  input  logic [4:0]  rb, // source byte read, also selects the read pair
  input  logic [15:0] wd, // write data, low byte for byte writes
  output logic [7:0]  rd,
  output logic [7:0]  rr,
  output logic [15:0] rw
);
  import rp8_pkg::*;

  gpr_t regs;

  // plain storage, contents undefined until written
  always_ff @(posedge clk) begin
    if (we) begin
      if (ww) begin
        regs.pair[wa[4:1]] <= wd;
      end else begin
        regs.idx[wa] <= wd[7:0];
      end
    end
  end

  assign rd = regs.idx[ra];
  assign rr = regs.idx[rb];
  assign rw = regs.pair[rb[4:1]]; // movw source pair

endmodule

// ==== rtl/rp8_pc.sv ====
// rp8 program counter with next fetch address select
`timescale 1ns/1ns

module rp8_pc (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      pc_load, // advance to bp_adr
  input  logic                      insn_ok, // word executes this cycle
  input  logic                      br_en,   // rjmp taken
  input  logic signed [11:0]        br_off,  // word offset from pc + 1
  output logic [rp8_pkg::PAW-1:0]   bp_adr
);
  import rp8_pkg::*;

  logic [PAW-1:0] pc;     // address of the word now on the bus
  logic [PAW-1:0] pc_inc;
  logic [PAW-1:0] pc_tgt;

  assign pc_inc = pc + 1'b1;
  assign pc_tgt = pc_inc + br_off[PAW-1:0]; // wraps inside program space

  // branch, sequential, or hold the outstanding address while stalled
  assign bp_adr = (insn_ok & br_en) ? pc_tgt :
                  pc_load           ? pc_inc : pc;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      pc <= '1; // so the first increment lands on 0
    end else if (pc_load) begin
      pc <= bp_adr;
    end
  end

endmodule

// ==== rtl/rp8_fetch_fsm.sv ====
// rp8 fetch sequencer, steps reset/first/run and qualifies the program word
`timescale 1ns/1ns

module rp8_fetch_fsm (
  input  logic clk,
  input  logic rst,
  input  logic bp_rdy,  // word on bp_rdt belongs to the outstanding address
  output logic bp_vld,  // fetch request
  output logic pc_load, // pc takes bp_adr this edge
  output logic insn_ok  // current word is executed
);
  import rp8_pkg::*;

  fetch_state_t state;
  fetch_state_t state_nxt;

  ////////////////////////////////////////////////////////////
  // state register
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (state)
      FS_RESET: state_nxt = FS_FIRST;
      FS_FIRST: state_nxt = FS_RUN; // no word to wait for yet
      default:  state_nxt = FS_RUN; // run forever
    endcase
  end

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state <= FS_RESET;
    end else begin
      state <= state_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  assign bp_vld  = (state != FS_RESET);
  assign insn_ok = (state == FS_RUN) & bp_rdy;
  assign pc_load = (state == FS_FIRST) | insn_ok; // first fetch, then each accepted word

endmodule

// ==== rtl/rp8_spr_io.sv ====
// rp8 status register and i/o port, sreg mapped internally at 0x3f
`timescale 1ns/1ns

module rp8_spr_io (
  input  logic           clk,
  input  logic           rst,
  input  logic           we,        // out executes
  input  logic           re,        // in executes
  input  logic [5:0]     ad,
  input  logic [7:0]     wd,        // out source register
  input  rp8_pkg::sreg_t alu_flags,
  input  rp8_pkg::sreg_t mask,      // flags the current insn updates
  input  logic [7:0]     io_rdt,
  output rp8_pkg::sreg_t sreg,
  output logic [7:0]     io_val,    // read value seen by in
  output logic [7:0]     io_wdt,
  output logic [5:0]     io_adr,
  output logic           io_wen,
  output logic           io_ren
);
  import rp8_pkg::*;

  logic ext; // address lies on the external bus

  // out to sreg wins over the flag merge
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      sreg <= '0;
    end else if (we && (ad == IOA_SREG)) begin
      sreg <= wd;
    end else begin
      sreg <= (alu_flags & mask) | (sreg & ~mask);
    end
  end

  assign ext    = (ad < IOA_SPR_BASE);
  assign io_wen = we & ext;
  assign io_ren = re & ext;
  assign io_adr = ad;
  assign io_wdt = wd;

  assign io_val = (ad == IOA_SREG) ? sreg : io_rdt;

endmodule

// ==== rtl/rp8_decoder.sv ====
// rp8 instruction decoder, one program word to register, alu, status, i/o and branch controls
`timescale 1ns/1ns

module rp8_decoder (
  input  logic [rp8_pkg::IW-1:0] insn,
  input  logic                   insn_ok,  // qualifies every enable
  input  logic [7:0]             rd,
  input  logic [7:0]             rr,
  input  logic [15:0]            rw,
  input  logic                   sreg_c,
  input  logic [7:0]             io_val,
  output rp8_pkg::alu_mode_t     alu_mode,
  output logic [7:0]             alu_a,
  output logic [7:0]             alu_b,
  output logic                   alu_ci,
  output logic                   gpr_we,
  output logic                   gpr_ww,
  output logic [4:0]             gpr_wa,
  output logic [4:0]             gpr_ra,
  output logic [4:0]             gpr_rb,
  output logic [15:0]            gpr_wd,   // move data for in and movw
  output logic                   gpr_wsel_io,
  output logic                   gpr_wsel_pair,
  output rp8_pkg::sreg_t         srg_mask,
  output logic                   iou_we,
  output logic                   iou_re,
  output logic [5:0]             iou_ad,
  output logic                   br_en,
  output logic signed [11:0]     br_off
);
  import rp8_pkg::*;

  logic [4:0] db;  // full range byte, rd field
  logic [4:0] rb;  // full range byte, rr field
  logic [4:0] dh;  // upper half, immediate ops
  logic [7:0] kb;  // 8 bit immediate
  logic       imm; // cpi/sbci/subi/ori/andi/ldi
  // raw controls, qualified at the bottom
  logic       we_raw;
  logic       iow_raw;
  logic       ior_raw;
  logic       br_raw;
  sreg_t      msk_raw;

  assign db  = insn[8:4];
  assign rb  = {insn[9], insn[3:0]};
  assign dh  = {1'b1, insn[7:4]};
  assign kb  = {insn[11:8], insn[3:0]};
  assign imm = (insn[15:12] inside {4'h3, 4'h4, 4'h5, 4'h6, 4'h7, 4'he});

  assign alu_a  = rd;
  assign alu_b  = imm ? kb : rr;
  assign iou_ad = {insn[10:9], insn[3:0]};
  assign br_off = insn[11:0];
  assign gpr_wd = gpr_wsel_pair ? rw : {8'h00, io_val};

  ////////////////////////////////////////////////////////////
  // pattern match, first hit wins, anything else is a nop
  ////////////////////////////////////////////////////////////

  always_comb begin
    alu_mode      = ALU_MOV;
    alu_ci        = 1'b0;
    we_raw        = 1'b0;
    gpr_ww        = 1'b0;
    gpr_wa        = imm ? dh : db;
    gpr_ra        = imm ? dh : db;
    gpr_rb        = rb;
    gpr_wsel_io   = 1'b0;
    gpr_wsel_pair = 1'b0;
    msk_raw       = '0;
    iow_raw       = 1'b0;
    ior_raw       = 1'b0;
    br_raw        = 1'b0;
    casez (insn)
      16'b0000_0001_????_????: begin // movw, pairs given by field * 2
        we_raw        = 1'b1;
        gpr_ww        = 1'b1;
        gpr_wa        = {insn[7:4], 1'b0};
        gpr_rb        = {insn[3:0], 1'b0};
        gpr_wsel_pair = 1'b1;
      end
      16'b000?_11??_????_????: begin // add, adc
        alu_mode = ALU_ADD;
        alu_ci   = sreg_c & insn[12];
        we_raw   = 1'b1;
        msk_raw  = MSK_ARITH;
      end
      16'b000?_01??_????_????, // cpc, cp
      16'b000?_10??_????_????, // sbc, sub
      16'b0011_????_????_????, // cpi
      16'b010?_????_????_????: begin // sbci, subi
        alu_mode = ALU_SUB;
        alu_ci   = sreg_c & ~insn[12]; // carry forms have bit 12 clear
        we_raw   = imm ? insn[14] : insn[11]; // compares write nothing
        msk_raw  = MSK_ARITH;
      end
      16'b0010_00??_????_????, 16'b0111_????_????_????: begin // and, andi
        alu_mode = ALU_AND;
        we_raw   = 1'b1;
        msk_raw  = MSK_LOGIC;
      end
      16'b0010_10??_????_????, 16'b0110_????_????_????: begin // or, ori
        alu_mode = ALU_OR;
        we_raw   = 1'b1;
        msk_raw  = MSK_LOGIC;
      end
      16'b0010_01??_????_????: begin // eor
        alu_mode = ALU_EOR;
        we_raw   = 1'b1;
        msk_raw  = MSK_LOGIC;
      end
      16'b0010_11??_????_????, 16'b1110_????_????_????: begin // mov, ldi via pass
        we_raw = 1'b1;
      end
      16'b1011_0???_????_????: begin // in
        we_raw      = 1'b1;
        gpr_wsel_io = 1'b1;
        ior_raw     = 1'b1;
      end
      16'b1011_1???_????_????: iow_raw = 1'b1; // out, source on ra
      16'b1100_????_????_????: br_raw  = 1'b1; // rjmp
      default: ;
    endcase
  end

  // nothing acts unless the word is accepted
  assign gpr_we   = insn_ok & we_raw;
  assign iou_we   = insn_ok & iow_raw;
  assign iou_re   = insn_ok & ior_raw;
  assign br_en    = insn_ok & br_raw;
  assign srg_mask = insn_ok ? msk_raw : '0;

endmodule

// ==== rtl/rp8_core.sv ====
// rp8 core top, fetch, decode, register file, alu and status/io units
`timescale 1ns/1ns

module rp8_core (
  input  logic                      clk,
  input  logic                      rst,
  // program bus
  output logic                      bp_vld,
  output logic [rp8_pkg::PAW-1:0]   bp_adr,
  input  logic [rp8_pkg::IW-1:0]    bp_rdt,
  input  logic                      bp_rdy,
  // i/o bus
  output logic                      io_wen,
  output logic                      io_ren,
  output logic [5:0]                io_adr,
  output logic [7:0]                io_wdt,
  input  logic [7:0]                io_rdt
);
  import rp8_pkg::*;

  logic               pc_load;
  logic               insn_ok;
  // alu
  alu_mode_t          alu_mode;
  logic [7:0]         alu_a;
  logic [7:0]         alu_b;
  logic               alu_ci;
  logic [7:0]         alu_res;
  sreg_t              alu_flags;
  // registers
  logic               gpr_we;
  logic               gpr_ww;
  logic [4:0]         gpr_wa;
  logic [4:0]         gpr_ra;
  logic [4:0]         gpr_rb;
  logic [15:0]        gpr_wd;
  logic [15:0]        gpr_wdat;
  logic               gpr_wsel_io;
  logic               gpr_wsel_pair;
  logic [7:0]         rd;
  logic [7:0]         rr;
  logic [15:0]        rw;
  // status, i/o, branch
  sreg_t              srg_mask;
  sreg_t              sreg;
  logic               iou_we;
  logic               iou_re;
  logic [5:0]         iou_ad;
  logic [7:0]         io_val;
  logic               br_en;
  logic signed [11:0] br_off;

  ////////////////////////////////////////////////////////////
  // fetch
  ////////////////////////////////////////////////////////////

  rp8_fetch_fsm u_fetch (
    .clk     (clk),
    .rst     (rst),
    .bp_rdy  (bp_rdy),
    .bp_vld  (bp_vld),
    .pc_load (pc_load),
    .insn_ok (insn_ok)
  );

  rp8_pc u_pc (
    .clk     (clk),
    .rst     (rst),
    .pc_load (pc_load),
    .insn_ok (insn_ok),
    .br_en   (br_en),
    .br_off  (br_off),
    .bp_adr  (bp_adr)
  );

  ////////////////////////////////////////////////////////////
  // decode and execute
  ////////////////////////////////////////////////////////////

  rp8_decoder u_dec (
    .insn          (bp_rdt),
    .insn_ok       (insn_ok),
    .rd            (rd),
    .rr            (rr),
    .rw            (rw),
    .sreg_c        (sreg.c),
    .io_val        (io_val),
    .alu_mode      (alu_mode),
    .alu_a         (alu_a),
    .alu_b         (alu_b),
    .alu_ci        (alu_ci),
    .gpr_we        (gpr_we),
    .gpr_ww        (gpr_ww),
    .gpr_wa        (gpr_wa),
    .gpr_ra        (gpr_ra),
    .gpr_rb        (gpr_rb),
    .gpr_wd        (gpr_wd),
    .gpr_wsel_io   (gpr_wsel_io),
    .gpr_wsel_pair (gpr_wsel_pair),
    .srg_mask      (srg_mask),
    .iou_we        (iou_we),
    .iou_re        (iou_re),
    .iou_ad        (iou_ad),
    .br_en         (br_en),
    .br_off        (br_off)
  );

  // register write data, moves bypass the alu result
  assign gpr_wdat = (gpr_wsel_io | gpr_wsel_pair) ? gpr_wd : {8'h00, alu_res};

  rp8_gpr u_gpr (
    .clk (clk),
    .we  (gpr_we),
    .ww  (gpr_ww),
    .wa  (gpr_wa),
    .ra  (gpr_ra),
    .rb  (gpr_rb),
    .wd  (gpr_wdat),
    .rd  (rd),
    .rr  (rr),
    .rw  (rw)
  );

  rp8_alu u_alu (
    .mode  (alu_mode),
    .a     (alu_a),
    .b     (alu_b),
    .ci    (alu_ci),
    .res   (alu_res),
    .flags (alu_flags)
  );

  rp8_spr_io u_spr_io (
    .clk       (clk),
    .rst       (rst),
    .we        (iou_we),
    .re        (iou_re),
    .ad        (iou_ad),
    .wd        (rd),        // out source register
    .alu_flags (alu_flags),
    .mask      (srg_mask),
    .io_rdt    (io_rdt),
    .sreg      (sreg),
    .io_val    (io_val),
    .io_wdt    (io_wdt),
    .io_adr    (io_adr),
    .io_wen    (io_wen),
    .io_ren    (io_ren)
  );

endmodule

// ==== verification/rp8_tb_mem.sv ====
// rp8 testbench program memory with random ready, plus the i/o read-data model
`timescale 1ns/1ns

module rp8_tb_mem (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    bp_vld,
  input  logic [rp8_pkg::PAW-1:0] bp_adr,
  output logic [15:0]             bp_rdt,
  output logic                    bp_rdy,
  input  logic [5:0]              io_adr,
  output logic [7:0]              io_rdt
);
  import rp8_pkg::*;

  logic [15:0]    mem [0:(1<<PAW)-1]; // loaded by the testbench top
  logic [31:0]    lfsr;
  logic [PAW-1:0] adr_q;              // address taken at the last edge
  logic           vld_q;
  logic           bit0;
  logic           bit1;

  // fibonacci lfsr, taps 32 22 2 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial begin
    for (int i = 0; i < (1 << PAW); i++) begin
      mem[i] = {5'b11111, i[PAW-1:0]}; // decodes as nop, tagged with its address
    end
    lfsr   = 32'h8a1b5d0e;
    bp_rdt = 16'h0000;
    bp_rdy = 1'b0;
  end

  ////////////////////////////////////////////////////////////
  // one cycle read, ready is random but never after an idle cycle
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    adr_q = bp_adr;
    vld_q = bp_vld & ~rst;
    lfsr  = lfsr_step(lfsr);
    bit0  = lfsr[0];
    lfsr  = lfsr_step(lfsr);
    bit1  = lfsr[0];
    #1;
    bp_rdt = mem[adr_q];
    bp_rdy = vld_q & (bit0 | bit1); // about three ready cycles in four
  end

  assign io_rdt = {2'b00, io_adr} ^ 8'ha5; // address tagged read data

endmodule

// ==== verification/rp8_tb.sv ====
// rp8 core testbench, builds a test program with a reference model and checks the i/o writes
`timescale 1ns/1ns

module rp8_tb;
  import rp8_pkg::*;

  logic           clk;
  logic           rst;
  logic           bp_vld;
  logic [PAW-1:0] bp_adr;
  logic [15:0]    bp_rdt;
  logic           bp_rdy;
  logic           io_wen;
  logic           io_ren;
  logic [5:0]     io_adr;
  logic [7:0]     io_wdt;
  logic [7:0]     io_rdt;

  // reference state and program image
  logic [7:0]  r [0:31];
  logic [7:0]  sr;
  logic [15:0] prog [0:63];
  logic [5:0]  exp_adr [0:63];
  logic [7:0]  exp_dat [0:63];
  logic [5:0]  rd_adr [0:15];  // external reads in program order
  int          plen;
  int          exp_n;
  int          wr_idx;
  int          rd_n;
  int          rd_idx;
  int          cycles;
  int          err_val;
  int          err_proto;
  logic        rst_q;
  logic        fetch_seen;

  rp8_core u_rp8_core (
    .clk    (clk),
    .rst    (rst),
    .bp_vld (bp_vld),
    .bp_adr (bp_adr),
    .bp_rdt (bp_rdt),
    .bp_rdy (bp_rdy),
    .io_wen (io_wen),
    .io_ren (io_ren),
    .io_adr (io_adr),
    .io_wdt (io_wdt),
    .io_rdt (io_rdt)
  );

  rp8_tb_mem u_mem (
    .clk    (clk),
    .rst    (rst),
    .bp_vld (bp_vld),
    .bp_adr (bp_adr),
    .bp_rdt (bp_rdt),
    .bp_rdy (bp_rdy),
    .io_adr (io_adr),
    .io_rdt (io_rdt)
  );

  ////////////////////////////////////////////////////////////
  // program builder with avr byte rules
  ////////////////////////////////////////////////////////////

  task automatic emit(input logic [15:0] w);
    prog[plen] = w;
    plen++;
  endtask

  // add or subtract with carry, flags from widened integer sums
  task automatic arith(input logic sub, input logic [7:0] a, input logic [7:0] b,
                       input logic ci, output logic [7:0] res);
    int   full; // unsigned byte result
    int   half; // low nibble result
    int   sgn;  // two's complement result
    logic h;
    logic v;
    logic c;
    if (sub) begin
      full = int'(a) - int'(b) - int'(ci);
      half = int'(a[3:0]) - int'(b[3:0]) - int'(ci);
      sgn  = int'($signed(a)) - int'($signed(b)) - int'(ci);
      c    = (full < 0);  // borrow out of bit 7
      h    = (half < 0);  // borrow out of bit 3
    end else begin
      full = int'(a) + int'(b) + int'(ci);
      half = int'(a[3:0]) + int'(b[3:0]) + int'(ci);
      sgn  = int'($signed(a)) + int'($signed(b)) + int'(ci);
      c    = (full > 255);
      h    = (half > 15);
    end
    v       = (sgn > 127) || (sgn < -128); // outside signed byte range
    res     = full[7:0];
    sr[5:0] = {h, res[7] ^ v, v, res[7], res == 8'h00, c};
  endtask

  task automatic logic_flags(input logic [7:0] res);
    sr[4:1] = {res[7], 1'b0, res[7], res == 8'h00}; // h and c untouched
  endtask

  task automatic ldi(input logic [4:0] d, input logic [7:0] k);
    emit({4'he, k[7:4], d[3:0], k[3:0]});
    r[d] = k;
  endtask

  // register-register ops, op is the top six opcode bits
  task automatic op_rr(input logic [5:0] op, input logic [4:0] d, input logic [4:0] s);
    logic [7:0] res;
    emit({op, s[4], d, s[3:0]});
    case (op)
      6'b000011: begin // add
        arith(1'b0, r[d], r[s], 1'b0, res);
        r[d] = res;
      end
      6'b000111: begin // adc
        arith(1'b0, r[d], r[s], sr[0], res);
        r[d] = res;
      end
      6'b000110: begin // sub
        arith(1'b1, r[d], r[s], 1'b0, res);
        r[d] = res;
      end
      6'b000010: begin // sbc
        arith(1'b1, r[d], r[s], sr[0], res);
        r[d] = res;
      end
      6'b000101: arith(1'b1, r[d], r[s], 1'b0, res); // cp
      6'b000001: arith(1'b1, r[d], r[s], sr[0], res); // cpc
      6'b001000: begin
        r[d] = r[d] & r[s];
        logic_flags(r[d]);
      end
      6'b001001: begin
        r[d] = r[d] ^ r[s];
        logic_flags(r[d]);
      end
      6'b001010: begin
        r[d] = r[d] | r[s];
        logic_flags(r[d]);
      end
      default:   r[d] = r[s]; // mov
    endcase
  endtask

  // immediate ops on r16..r31
  task automatic op_imm(input logic [3:0] op, input logic [4:0] d, input logic [7:0] k);
    logic [7:0] res;
    emit({op, k[7:4], d[3:0], k[3:0]});
    case (op)
      4'h5: begin // subi
        arith(1'b1, r[d], k, 1'b0, res);
        r[d] = res;
      end
      4'h4: begin // sbci
        arith(1'b1, r[d], k, sr[0], res);
        r[d] = res;
      end
      4'h3: arith(1'b1, r[d], k, 1'b0, res); // cpi
      4'h6: begin
        r[d] = r[d] | k;
        logic_flags(r[d]);
      end
      default: begin // andi
        r[d] = r[d] & k;
        logic_flags(r[d]);
      end
    endcase
  endtask

  task automatic io_out(input logic [5:0] a, input logic [4:0] s);
    emit({5'b10111, a[5:4], s, a[3:0]});
    if (a == 6'h3f) begin
      sr = r[s]; // every flag replaced
    end
    if (a < 6'h38) begin
      exp_adr[exp_n] = a;
      exp_dat[exp_n] = r[s];
      exp_n++;
    end
  endtask

  task automatic io_in(input logic [4:0] d, input logic [5:0] a);
    emit({5'b10110, a[5:4], d, a[3:0]});
    r[d] = (a == 6'h3f) ? sr : ({2'b00, a} ^ 8'ha5);
    if (a < 6'h38) begin
      rd_adr[rd_n] = a;
      rd_n++;
    end
  endtask

  task automatic movw(input logic [4:0] d, input logic [4:0] s);
    emit({8'h01, d[4:1], s[4:1]});
    r[d]        = r[s];
    r[d | 5'd1] = r[s | 5'd1];
  endtask

  task automatic build_program();
    plen  = 0;
    exp_n = 0;
    rd_n  = 0;
    sr    = 8'h00;
    ldi(5'd16, 8'h9c);
    ldi(5'd17, 8'h7b);
    op_rr(6'b000011, 5'd16, 5'd17); // add with carry out
    io_in(5'd20, 6'h3f);
    io_out(6'h01, 5'd20);
    io_out(6'h01, 5'd16);
    op_rr(6'b000111, 5'd16, 5'd17); // adc
    io_out(6'h01, 5'd16);
    op_rr(6'b000010, 5'd16, 5'd17); // sbc
    io_out(6'h01, 5'd16);
    op_imm(4'h5, 5'd16, 8'h21);     // subi
    io_out(6'h01, 5'd16);
    op_imm(4'h4, 5'd16, 8'h05);     // sbci
    io_out(6'h01, 5'd16);
    op_imm(4'h3, 5'd16, 8'h10);     // cpi
    op_rr(6'b000101, 5'd16, 5'd17); // cp
    op_rr(6'b000001, 5'd16, 5'd17); // cpc
    op_imm(4'h7, 5'd16, 8'hf0);     // andi
    io_out(6'h01, 5'd16);
    op_imm(4'h6, 5'd16, 8'h0c);     // ori
    io_out(6'h01, 5'd16);
    op_rr(6'b001000, 5'd16, 5'd17); // and
    io_out(6'h01, 5'd16);
    op_rr(6'b001010, 5'd16, 5'd17); // or
    io_out(6'h01, 5'd16);
    op_rr(6'b001001, 5'd16, 5'd17); // eor
    io_out(6'h01, 5'd16);
    op_rr(6'b001011, 5'd21, 5'd17); // mov
    io_out(6'h01, 5'd21);
    movw(5'd22, 5'd16);
    io_out(6'h01, 5'd22);
    io_out(6'h01, 5'd23);
    io_in(5'd24, 6'h05);
    io_out(6'h01, 5'd24);
    ldi(5'd18, 8'h42);
    ldi(5'd19, 8'h42);
    op_rr(6'b000110, 5'd19, 5'd18); // sub to zero
    io_in(5'd20, 6'h3f);
    io_out(6'h01, 5'd20);
    ldi(5'd26, 8'hb5);
    io_out(6'h3f, 5'd26);           // sreg written directly, stays off the bus
    io_in(5'd20, 6'h3f);
    io_out(6'h01, 5'd20);
    ldi(5'd25, 8'hee);
    emit({4'hc, 12'h001});          // rjmp over the next word
    emit({5'b10111, 2'b00, 5'd25, 4'h2}); // skipped out, never expected
    io_out(6'h02, 5'd16);
    emit({4'hc, 12'hfff});          // park in a self loop
  endtask

  ////////////////////////////////////////////////////////////
  // clock, reset, sequencing
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst        = 1'b1;
    rst_q      = 1'b1;
    fetch_seen = 1'b0;
    wr_idx     = 0;
    rd_idx     = 0;
    cycles     = 0;
    err_val    = 0;
    err_proto  = 0;
    build_program();
    #1;
    for (int i = 0; i < plen; i++) begin
      u_mem.mem[i] = prog[i]; // after the memory fill at time 0
    end
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    wait (wr_idx >= exp_n);
    repeat (16) @(posedge clk); // room for any stray write
    assert (rd_idx == rd_n) else begin
      err_proto++;
      $display("ERROR t=%0t io_ren pulses got %0d exp %0d", $time, rd_idx, rd_n);
    end
    $display("run done, %0d value errors, %0d protocol errors", err_val, err_proto);
    if (err_val == 0 && err_proto == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // run limit scales with the program
  always @(posedge clk) begin
    cycles++;
    if (cycles == 40 * plen) begin
      $display("timeout after %0d cycles, %0d of %0d writes seen", cycles, wr_idx, exp_n);
      $display("Test FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks, sampled at the rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst || rst_q) begin
      assert (!bp_vld && !io_wen && !io_ren) else begin
        err_proto++;
        $display("bus active during or right after reset at %0t", $time);
      end
    end
    rst_q <= rst;
    if (bp_vld && !fetch_seen) begin
      fetch_seen = 1'b1;
      assert (bp_adr == '0) else begin
        err_val++;
        $display("ERROR t=%0t bp_adr got %h exp %h", $time, bp_adr, 11'h000);
      end
    end
    assert (!((io_wen || io_ren) && io_adr >= 6'h38)) else begin
      err_proto++;
      $display("internal address %h reached the i/o bus at %0t", io_adr, $time);
    end
    if (io_ren) begin
      if (rd_idx < rd_n) begin
        assert (io_adr == rd_adr[rd_idx]) else begin
          err_val++;
          $display("ERROR t=%0t io_adr got %h exp %h", $time, io_adr, rd_adr[rd_idx]);
        end
      end
      rd_idx++;
    end
    if (io_wen) begin
      assert (io_wdt != 8'hee) else begin
        err_proto++;
        $display("the out behind the rjmp was executed at %0t", $time);
      end
      assert (wr_idx < exp_n) else begin
        err_proto++;
        $display("extra i/o write at %0t beyond the expected list", $time);
      end
      if (wr_idx < exp_n) begin
        assert (io_adr == exp_adr[wr_idx]) else begin
          err_val++;
          $display("ERROR t=%0t io_adr got %h exp %h", $time, io_adr, exp_adr[wr_idx]);
        end
        assert (io_wdt == exp_dat[wr_idx]) else begin
          err_val++;
          $display("ERROR t=%0t io_wdt got %h exp %h", $time, io_wdt, exp_dat[wr_idx]);
        end
      end
      wr_idx++;
    end
  end

endmodule

// ==== flist.f ====
rtl/rp8_pkg.sv
rtl/rp8_alu.sv
rtl/rp8_gpr.sv
rtl/rp8_pc.sv
rtl/rp8_fetch_fsm.sv
rtl/rp8_spr_io.sv
rtl/rp8_decoder.sv
rtl/rp8_core.sv
verification/rp8_tb_mem.sv
verification/rp8_tb.sv

// ==== Makefile ====
# Verilator build and run for the rp8 core testbench

VERILATOR ?= verilator
TOP       ?= rp8_tb
FLIST     ?= flist.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
